//--- fm_pkg.sv
package fm_pkg;

    typedef logic [19:0] phase_t;          // phase accumulator, wraps mod 2^20
    typedef logic [9:0]  fnum_t;           // frequency number
    typedef logic [2:0]  block_t;          // octave, left shift of fnum
    typedef logic [2:0]  level_t;          // attenuation, arith right shift
    typedef logic [1:0]  wave_t;           // waveform select
    typedef logic signed [15:0] sample_t;  // audio sample
    typedef logic signed [17:0] acc_t;     // mixer sum, headroom for 4 ops
    typedef logic [31:0] wb_data_t;        // wishbone data word

    // waveform select codes
    localparam wave_t WAVE_OFF    = 2'd0;
    localparam wave_t WAVE_SQUARE = 2'd1;
    localparam wave_t WAVE_SAW    = 2'd2;
    localparam wave_t WAVE_TRI    = 2'd3;

    // one operator word, bits 20..0 of the register
    typedef struct packed {
        logic   kon;                       // key on
        logic   pan_r;                     // route to right
        logic   pan_l;                     // route to left
        level_t level;
        wave_t  wave;
        block_t block;
        fnum_t  fnum;
    } op_cfg_t;

    localparam int CFG_W = $bits(op_cfg_t); // 21

    typedef struct packed {
        sample_t left;                     // sent first
        sample_t right;
    } frame_t;

    typedef enum logic [1:0] {
        IDLE,                              // waiting for sample tick
        RUN,                               // one slot per clock
        DONE                               // gap before next tick
    } seq_state_t;

endpackage

//--- fm_regs.sv
`timescale 1ns/1ps

module fm_regs #(
    parameter  int NUM_OPS = 4,
    localparam int SLOT_W  = (NUM_OPS > 1) ? $clog2(NUM_OPS) : 1
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [3:0]                        wb_adr,     // word index
    input  fm_pkg::wb_data_t                  wb_dat_w,
    output fm_pkg::wb_data_t                  wb_dat_r,
    output logic                              wb_ack,
    output fm_pkg::op_cfg_t [NUM_OPS-1:0]     cfg
);

    logic              req;        // new request, not yet acked
    logic              in_range;   // adr hits an operator
    logic [SLOT_W-1:0] idx;

    always_comb begin
        req      = wb_cyc && wb_stb && !wb_ack; // ack lasts a single clock
        in_range = (wb_adr < NUM_OPS);
        idx      = wb_adr[SLOT_W-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            cfg      <= '0;            // all operators silent after reset
        end else begin
            wb_ack <= req;
            if (req && wb_we && in_range) begin
                cfg[idx] <= fm_pkg::op_cfg_t'(wb_dat_w[fm_pkg::CFG_W-1:0]); // upper bits dropped
            end
            if (req && !wb_we) begin
                // zero-extended readback, out of range reads zero
                wb_dat_r <= in_range ? fm_pkg::wb_data_t'(cfg[idx]) : '0;
            end
        end
    end

    // slave only answers a strobe seen on the previous clock
    a_ack_after_stb : assert property (
        @(posedge clk) disable iff (!arst_n)
        !wb_stb |=> !wb_ack
    );

endmodule

//--- fm_sequencer.sv
`timescale 1ns/1ps

module fm_sequencer #(
    parameter  int NUM_OPS    = 4,
    parameter  int SAMPLE_DIV = 160,   // >= 136 so one i2s frame fits
    localparam int SLOT_W     = (NUM_OPS > 1) ? $clog2(NUM_OPS) : 1,
    localparam int DIV_W      = $clog2(SAMPLE_DIV)
) (
    input  logic              clk,
    input  logic              arst_n,
    output logic              slot_valid,
    output logic [SLOT_W-1:0] slot,
    output logic              frame_start,
    output logic              frame_last
);

    logic [DIV_W-1:0]    div_cnt;          // sample period counter
    logic                tick;             // one clock per sample period
    fm_pkg::seq_state_t  state;

    always_comb begin
        tick        = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
        frame_start = tick && (state == fm_pkg::IDLE);
        slot_valid  = (state == fm_pkg::RUN);
        frame_last  = slot_valid && (slot == SLOT_W'(NUM_OPS - 1));
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= fm_pkg::IDLE;
            slot  <= '0;
        end else begin
            case (state)
                fm_pkg::IDLE: begin
                    slot <= '0;
                    if (tick) state <= fm_pkg::RUN;
                end
                fm_pkg::RUN: begin
                    slot <= slot + 1'b1;
                    if (frame_last) state <= fm_pkg::DONE; // last operator this clock
                end
                default: state <= fm_pkg::IDLE;         // DONE lasts one clock
            endcase
        end
    end

    a_slot_in_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        slot_valid |-> (slot < NUM_OPS)
    );

endmodule

//--- fm_phase.sv
`timescale 1ns/1ps

module fm_phase #(
    parameter  int NUM_OPS = 4,
    localparam int SLOT_W  = (NUM_OPS > 1) ? $clog2(NUM_OPS) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          slot_valid,
    input  logic [SLOT_W-1:0]             slot,
    input  fm_pkg::op_cfg_t [NUM_OPS-1:0] cfg,
    output fm_pkg::phase_t                phase,
    output logic [SLOT_W-1:0]             slot_q,
    output logic                          valid_q
);

    fm_pkg::phase_t  phase_mem [NUM_OPS];   // one accumulator per operator
    fm_pkg::op_cfg_t cur_cfg;
    fm_pkg::phase_t  step;                  // fnum << block
    fm_pkg::phase_t  next_phase;

    always_comb begin
        cur_cfg    = cfg[slot];
        step       = fm_pkg::phase_t'(cur_cfg.fnum) << cur_cfg.block;
        next_phase = cur_cfg.kon ? (phase_mem[slot] + step) : '0; // key off restarts at 0
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            for (int i = 0; i < NUM_OPS; i++) begin
                phase_mem[i] <= '0;
            end
        end else begin
            valid_q <= slot_valid;
            if (slot_valid) phase_mem[slot] <= next_phase;
        end
    end

    // pipeline payload, qualified by valid_q
    always_ff @(posedge clk) begin
        phase  <= next_phase;
        slot_q <= slot;
    end

endmodule

//--- fm_waveform.sv
`timescale 1ns/1ps

module fm_waveform #(
    parameter  int NUM_OPS = 4,
    localparam int SLOT_W  = (NUM_OPS > 1) ? $clog2(NUM_OPS) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          valid_q,
    input  logic [SLOT_W-1:0]             slot_q,
    input  fm_pkg::phase_t                phase,
    input  fm_pkg::op_cfg_t [NUM_OPS-1:0] cfg,
    output fm_pkg::sample_t               sample,
    output logic                          pan_l,
    output logic                          pan_r,
    output logic                          sample_valid
);

    fm_pkg::op_cfg_t    cur_cfg;
    logic [7:0]         p;          // top phase bits
    logic signed [17:0] shape;      // full scale wave, room for the offsets
    fm_pkg::sample_t    sample_d;

    always_comb begin
        cur_cfg = cfg[slot_q];
        p       = phase[19:12];
        case (cur_cfg.wave)
            fm_pkg::WAVE_SQUARE: shape = p[7] ? -18'sd16384 : 18'sd16383;
            fm_pkg::WAVE_SAW:    shape = $signed({2'b00, p, 8'h00}) - 18'sd32768;
            fm_pkg::WAVE_TRI: begin
                if (!p[7]) shape = $signed({2'b00, p[6:0], 9'h000}) - 18'sd32768; // rising half
                else       shape = 18'sd32767 - $signed({2'b00, p[6:0], 9'h000}); // falling half
            end
            default:             shape = '0;
        endcase
        if (!cur_cfg.kon) shape = '0;                               // keyed off is silent
        sample_d = fm_pkg::sample_t'(shape >>> cur_cfg.level);      // attenuation
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) sample_valid <= 1'b0;
        else         sample_valid <= valid_q;
    end

    always_ff @(posedge clk) begin
        sample <= sample_d;
        pan_l  <= cur_cfg.pan_l;
        pan_r  <= cur_cfg.pan_r;
    end

endmodule

//--- fm_mixer.sv
`timescale 1ns/1ps

module fm_mixer (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            frame_start,
    input  logic            frame_last,
    input  logic            sample_valid,
    input  fm_pkg::sample_t sample,
    input  logic            pan_l,
    input  logic            pan_r,
    output fm_pkg::frame_t  frame,
    output logic            frame_valid
);

    fm_pkg::acc_t acc_l, acc_r;     // running sums
    fm_pkg::acc_t next_l, next_r;   // sums including this clock's sample
    logic         last_d1, last_d2; // frame_last aligned to the pipeline

    function automatic fm_pkg::sample_t sat(input fm_pkg::acc_t v);
        if (v > 18'sd32767)       return 16'sh7fff;
        else if (v < -18'sd32768) return 16'sh8000;
        else                      return fm_pkg::sample_t'(v);
    endfunction

    always_comb begin
        next_l = (frame_start ? '0 : acc_l)
               + ((sample_valid && pan_l) ? fm_pkg::acc_t'(sample) : '0);
        next_r = (frame_start ? '0 : acc_r)
               + ((sample_valid && pan_r) ? fm_pkg::acc_t'(sample) : '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_l       <= '0;
            acc_r       <= '0;
            last_d1     <= 1'b0;
            last_d2     <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            acc_l       <= next_l;
            acc_r       <= next_r;
            last_d1     <= frame_last;
            last_d2     <= last_d1;  // lines up with the last sample
            frame_valid <= last_d2;
        end
    end

    always_ff @(posedge clk) begin
        if (last_d2) frame <= '{left: sat(next_l), right: sat(next_r)};
    end

    // one frame per sample period
    a_frame_pulse : assert property (
        @(posedge clk) disable iff (!arst_n)
        frame_valid |=> !frame_valid
    );

endmodule

//--- i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           frame_valid,
    input  fm_pkg::frame_t frame,
    output logic           sclk,
    output logic           ws,
    output logic           sd
);

    logic [1:0]  div;       // clk/4
    logic        fall;      // sclk falls after this clock
    logic        active;    // frame loaded or being sent
    logic [5:0]  edge_cnt;  // falling edges since start, 0..32
    logic [31:0] sr;        // left then right, msb first

    always_comb begin
        sclk = div[1];
        fall = (div == 2'd3);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div      <= '0;
            active   <= 1'b0;
            edge_cnt <= '0;
            ws       <= 1'b1;           // idle is right channel
            sd       <= 1'b0;
        end else begin
            div <= div + 1'b1;
            if (!active) begin
                if (frame_valid) begin
                    active   <= 1'b1;   // start on next falling edge
                    edge_cnt <= '0;
                end
                if (fall) sd <= 1'b0;   // drop after the right lsb
            end else if (fall) begin
                edge_cnt <= edge_cnt + 1'b1;
                if (edge_cnt == 6'd0) begin
                    ws <= 1'b0;         // left, data one sclk later
                    sd <= 1'b0;
                end else begin
                    sd <= sr[31];
                end
                if (edge_cnt == 6'd16) ws <= 1'b1;      // left lsb goes out with this
                if (edge_cnt == 6'd32) active <= 1'b0;  // right lsb out
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && frame_valid)           sr <= frame;
        else if (fall && edge_cnt != 6'd0)    sr <= {sr[30:0], 1'b0};
    end

endmodule

//--- fm_synth.sv
`timescale 1ns/1ps

module fm_synth #(
    parameter  int NUM_OPS    = 4,
    parameter  int SAMPLE_DIV = 160,   // >= 136
    localparam int SLOT_W     = (NUM_OPS > 1) ? $clog2(NUM_OPS) : 1
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [3:0]         wb_adr,
    input  fm_pkg::wb_data_t   wb_dat_w,
    output fm_pkg::wb_data_t   wb_dat_r,
    output logic               wb_ack,
    output logic               i2s_sclk,
    output logic               i2s_ws,
    output logic               i2s_sd,
    output logic [NUM_OPS-1:0] led
);

    fm_pkg::op_cfg_t [NUM_OPS-1:0] cfg;
    logic                          slot_valid, frame_start, frame_last;
    logic [SLOT_W-1:0]             slot, slot_q;
    logic                          valid_q;
    fm_pkg::phase_t                phase;
    fm_pkg::sample_t               sample;
    logic                          pan_l, pan_r, sample_valid;
    fm_pkg::frame_t                frame;
    logic                          frame_valid;

    fm_regs #(.NUM_OPS(NUM_OPS)) fm_regs_inst (.*);

    fm_sequencer #(
        .NUM_OPS(NUM_OPS),
        .SAMPLE_DIV(SAMPLE_DIV)
    ) fm_sequencer_inst (.*);

    fm_phase #(.NUM_OPS(NUM_OPS)) fm_phase_inst (.*);     // slot -> phase, +1 clk

    fm_waveform #(.NUM_OPS(NUM_OPS)) fm_waveform_inst (.*); // phase -> sample, +1 clk

    fm_mixer fm_mixer_inst (.*);

    i2s_tx i2s_tx_inst (
        .clk(clk),
        .arst_n(arst_n),
        .frame_valid(frame_valid),
        .frame(frame),
        .sclk(i2s_sclk),
        .ws(i2s_ws),
        .sd(i2s_sd)
    );

    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) led[i] = cfg[i].kon; // lit while keyed on
    end

endmodule

//--- fm_synth_tb.sv
`timescale 1ns/1ps

module fm_synth_tb;

    localparam int NUM_OPS    = 4;     // dut defaults
    localparam int SAMPLE_DIV = 160;
    localparam int CLK_NS     = 100;
    localparam int SAFE_CLKS  = 120;   // latest access start after a frame start

    logic               clk, arst_n;
    logic               wb_cyc, wb_stb, wb_we, wb_ack;
    logic [3:0]         wb_adr;
    fm_pkg::wb_data_t   wb_dat_w, wb_dat_r;
    logic               i2s_sclk, i2s_ws, i2s_sd;
    logic [NUM_OPS-1:0] led;

    fm_pkg::op_cfg_t shadow [NUM_OPS];  // words the host has written
    int     ph_model [NUM_OPS];         // reference phases
    int     value_errs    = 0;
    int     missing_errs  = 0;
    int     check_left    = 0;          // frames still to compare
    time    frame_start_t = 0;          // last ws fall
    longint limit_ns      = 0;

    fm_synth fm_synth_inst (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .i2s_sclk(i2s_sclk), .i2s_ws(i2s_ws), .i2s_sd(i2s_sd), .led(led)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check_word(input fm_pkg::wb_data_t got, exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_sample(input fm_pkg::sample_t got, exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_led(input logic [NUM_OPS-1:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %0t: led got %b expected %b", $time, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_ws(input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("FAIL %0t: ws per bit got %h expected %h", $time, got, exp);
            value_errs++;
        end
    endtask

    // waveform rules, top 8 phase bits as p
    function automatic int wave_value(input fm_pkg::op_cfg_t c, input int ph);
        int p;
        int v;
        p = ph >> 12;
        case (c.wave)
            fm_pkg::WAVE_SQUARE: v = (p < 128) ? 16383 : -16384;
            fm_pkg::WAVE_SAW:    v = p * 256 - 32768;
            fm_pkg::WAVE_TRI:    v = (p < 128) ? p * 512 - 32768 : 32767 - (p - 128) * 512;
            default:             v = 0;
        endcase
        if (!c.kon) v = 0;
        return v >>> c.level;           // signed int, arithmetic
    endfunction

    function automatic fm_pkg::sample_t clamp(input int v);
        if (v > 32767)  return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return fm_pkg::sample_t'(v);
    endfunction

    // drive on the falling edge, look for ack at the next falling edges
    task automatic wb_access(input logic we, input logic [3:0] adr,
                             input fm_pkg::wb_data_t wdata, output fm_pkg::wb_data_t rdata);
        int n;
        n     = 0;
        rdata = '0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        while (n < 4) begin
            @(negedge clk);
            n++;
            if (wb_ack) break;
        end
        if (wb_ack) rdata = wb_dat_r;
        else begin
            $display("no Wishbone ack within 4 clocks for address %0d", adr);
            missing_errs++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // keep config changes away from the sample tick
    task automatic wait_access_window();
        while ($time - frame_start_t >= SAFE_CLKS * CLK_NS) @(negedge clk);
        repeat ($urandom % 4) @(negedge clk); // idle gap
    endtask

    initial begin : i2s_decoder
        fm_pkg::frame_t got;
        logic [31:0]    ws_seen;                // ws at each data bit
        int             sum_l, sum_r, v;
        @(posedge arst_n);
        frame_start_t = $time;
        forever begin
            @(negedge i2s_ws);                  // left word starts
            frame_start_t = $time;
            sum_l = 0;
            sum_r = 0;
            for (int i = 0; i < NUM_OPS; i++) begin // config as seen at the tick
                if (!shadow[i].kon) ph_model[i] = 0;
                else ph_model[i] = (ph_model[i] + (int'(shadow[i].fnum) << shadow[i].block))
                                   % 1048576;
                v = wave_value(shadow[i], ph_model[i]);
                if (shadow[i].pan_l) sum_l += v;
                if (shadow[i].pan_r) sum_r += v;
            end
            @(posedge i2s_sclk);                // one bit delay after ws
            for (int b = 31; b >= 0; b--) begin
                @(posedge i2s_sclk);
                got[b]     = i2s_sd;
                ws_seen[b] = i2s_ws;
            end
            if (check_left > 0) begin
                check_sample(got.left, clamp(sum_l), "left sample");
                check_sample(got.right, clamp(sum_r), "right sample");
                check_ws(ws_seen, 32'h0001_ffff); // high from the left lsb on
                check_left--;
            end
        end
    end

    initial begin : watchdog
        wait (limit_ns != 0);
        #(limit_ns);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("test failed");
        $finish;
    end

    initial begin : main
        int                 fd, n, a, clks, frames, accesses;
        logic [8*16-1:0]    tok;
        logic [8*128-1:0]   rest;
        logic [7:0]         cmd_q [$];
        int                 a_q [$];
        fm_pkg::wb_data_t   b_q [$];
        fm_pkg::wb_data_t   word, rd;
        logic [3:0]         adr;
        logic [NUM_OPS-1:0] kon_exp;
        void'($urandom(32'hca21_2431));
        clk      = 1'b0;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        frames   = 0;
        accesses = 0;
        for (int i = 0; i < NUM_OPS; i++) begin
            shadow[i]   = '0;
            ph_model[i] = 0;
        end
        fd = $fopen("fm_synth_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open fm_synth_tests.txt");
            missing_errs++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") n = $fgets(rest, fd);   // comment line
                else if (tok == "F") begin
                    n = $fscanf(fd, "%d", a);
                    cmd_q.push_back("F");
                    a_q.push_back(a);
                    b_q.push_back('0);
                    frames += a;
                end else begin                          // W or R
                    n = $fscanf(fd, "%d %h", a, word);
                    cmd_q.push_back(tok[7:0]);
                    a_q.push_back(a);
                    b_q.push_back(word);
                    accesses++;
                end
            end
            $fclose(fd);
        end
        limit_ns = (longint'(frames) + 4) * SAMPLE_DIV * CLK_NS
                 + longint'(accesses) * 100 * CLK_NS + 8 * CLK_NS;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        foreach (cmd_q[k]) begin
            adr = 4'(a_q[k]);
            case (cmd_q[k])
                "W": begin
                    wait_access_window();
                    wb_access(1'b1, adr, b_q[k], rd);
                    if (a_q[k] < NUM_OPS) shadow[a_q[k]] = fm_pkg::op_cfg_t'(b_q[k][20:0]);
                    for (int i = 0; i < NUM_OPS; i++) kon_exp[i] = shadow[i].kon;
                    check_led(led, kon_exp);
                end
                "R": begin
                    wait_access_window();
                    wb_access(1'b0, adr, '0, rd);
                    check_word(rd, b_q[k], "readback");
                end
                default: begin                          // frame check
                    check_left = a_q[k];
                    clks       = 0;
                    while (check_left > 0 && clks < (a_q[k] + 2) * SAMPLE_DIV) begin
                        @(negedge clk);
                        clks++;
                    end
                    if (check_left > 0) begin
                        $display("only %0d of %0d i2s frames arrived in %0d clocks",
                                 a_q[k] - check_left, a_q[k], clks);
                        missing_errs++;
                        check_left = 0;
                    end
                end
            endcase
        end
        $display("errors: %0d wrong values, %0d missing acks or frames", value_errs, missing_errs);
        if (value_errs == 0 && missing_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
fm_pkg.sv
fm_regs.sv
fm_sequencer.sv
fm_phase.sv
fm_waveform.sv
fm_mixer.sv
i2s_tx.sv
fm_synth.sv
fm_synth_tb.sv

//--- Bender.yml
package:
  name: fm_synth

sources:
  - fm_pkg.sv
  - fm_regs.sv
  - fm_sequencer.sv
  - fm_phase.sv
  - fm_waveform.sv
  - fm_mixer.sv
  - i2s_tx.sv
  - fm_synth.sv
  - target: simulation
    files:
      - fm_synth_tb.sv

//--- fm_synth_tests.txt
# W <op> <word hex> writes a word, R <op> <word hex> reads back and compares
# F <n> checks the next n i2s frames against the reference model
W 0 FFE01234
R 0 00001234
W 1 FFF01111
R 1 00101111
W 9 12345678
R 9 00000000
R 5 00000000
W 1 00000000
W 0 00000000
F 2
W 0 0014BFFF
R 0 0014BFFF
F 10
W 0 00000000
W 1 001956A1
W 2 001C7955
F 12
W 0 001C3FFF
W 1 001C3F00
W 2 001C5E00
W 3 001C7BFF
R 3 001C7BFF
F 12
W 3 00000000
F 2
W 3 001C7BFF
F 6
